// File: source/clock_pkg.sv
package clock_pkg;

    // one decimal digit, 0 to 9
    typedef logic [3:0] bcd_digit_t;

    // minute rollover, 59 wraps to 00
    localparam bcd_digit_t MINUTE_TENS_MAX  = 4'd5;
    localparam bcd_digit_t MINUTE_UNITS_MAX = 4'd9;

    localparam int SECONDS_MAX = 59;

    // 12-hour face, no zero hour
    localparam int HOUR_FIRST = 1;
    localparam int HOUR_LAST  = 12;

    // time after reset, 12:00
    localparam int RESET_HOURS   = 12;
    localparam int RESET_MINUTES = 0;

endpackage

// File: source/display_pkg.sv
package display_pkg;

    // active low, bit 0 is segment a up to bit 6 segment g
    typedef logic [6:0] segments_t;

    localparam segments_t SEG_BLANK = 7'b111_1111;

    localparam int DIGIT_COUNT = 4;

    function automatic segments_t encode_digit(input clock_pkg::bcd_digit_t digit);
        segments_t seg;
        case (digit)
            4'd0:    seg = 7'b100_0000;
            4'd1:    seg = 7'b111_1001;
            4'd2:    seg = 7'b010_0100;
            4'd3:    seg = 7'b011_0000;
            4'd4:    seg = 7'b001_1001;
            4'd5:    seg = 7'b001_0010;
            4'd6:    seg = 7'b000_0010;
            4'd7:    seg = 7'b111_1000;
            4'd8:    seg = 7'b000_0000;
            4'd9:    seg = 7'b001_0000;
            default: seg = SEG_BLANK; // not a decimal digit
        endcase
        return seg;
    endfunction

endpackage

// File: source/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
    parameter int CYCLES_PER_SECOND = 100_000_000
) (
    input  logic clk_100mhz,
    input  logic rst,
    output logic second_tick,
    output logic blink
);

    localparam int CNT_W = $clog2(CYCLES_PER_SECOND + 1);

    logic [CNT_W-1:0] cycle_cnt;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            cycle_cnt   <= '0;
            second_tick <= 1'b0;
            blink       <= 1'b0;
        end else begin
            second_tick <= 1'b0;
            if (cycle_cnt == CNT_W'(CYCLES_PER_SECOND - 1)) begin
                cycle_cnt   <= '0;
                second_tick <= 1'b1; // once per wrap
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
            blink <= (cycle_cnt >= CNT_W'(CYCLES_PER_SECOND / 2)); // high in upper half
        end
    end

endmodule

// File: source/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic clk_100mhz,
    input  logic rst,
    input  logic btn,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             btn_meta;
    logic             btn_sync;
    logic             level;     // accepted button level
    logic [CNT_W-1:0] stable_cnt;

    // two-flop synchronizer
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    // count while the synced input disagrees with the accepted level
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            level      <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
        end else begin
            press <= 1'b0;
            if (btn_sync == level) begin
                stable_cnt <= '0; // bounced back, start over
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                level      <= btn_sync;
                stable_cnt <= '0;
                press      <= btn_sync; // rising edge of accepted level only
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

// File: source/clock_control.sv
`timescale 1ns/1ps

module clock_control (
    input  logic clk_100mhz,
    input  logic rst,
    input  logic second_tick,
    input  logic blink,
    input  logic btn_min_press,
    input  logic btn_hr_press,
    input  logic hour_carry,
    output logic advance_min,
    output logic advance_hr,
    output logic blink_out
);

    localparam int SEC_W = $clog2(clock_pkg::SECONDS_MAX + 1);

    logic [SEC_W-1:0] sec_cnt;
    logic             sec_rollover;

    // outstanding advances, two sources per unit can land together
    logic [1:0] min_pending;
    logic [1:0] hr_pending;
    logic [1:0] min_total;
    logic [1:0] hr_total;
    logic       serve_min;
    logic       serve_hr;

    assign blink_out = blink;

    assign sec_rollover = second_tick && (sec_cnt == SEC_W'(clock_pkg::SECONDS_MAX));

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            sec_cnt <= '0;
        end else if (second_tick) begin
            if (sec_rollover)
                sec_cnt <= '0;
            else
                sec_cnt <= sec_cnt + 1'b1;
        end
    end

    // minute wins, hour waits a cycle
    always_comb begin
        min_total = min_pending + 2'(sec_rollover) + 2'(btn_min_press);
        hr_total  = hr_pending + 2'(hour_carry) + 2'(btn_hr_press);
        serve_min = (min_total != 2'd0);
        serve_hr  = !serve_min && (hr_total != 2'd0);
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            min_pending <= 2'd0;
            hr_pending  <= 2'd0;
            advance_min <= 1'b0;
            advance_hr  <= 1'b0;
        end else begin
            min_pending <= min_total - 2'(serve_min);
            hr_pending  <= hr_total - 2'(serve_hr);
            advance_min <= serve_min;
            advance_hr  <= serve_hr;
        end
    end

endmodule

// File: source/time_counter.sv
`timescale 1ns/1ps

module time_counter (
    input  logic                  clk_100mhz,
    input  logic                  rst,
    input  logic                  advance_min,
    input  logic                  advance_hr,
    output clock_pkg::bcd_digit_t min0,
    output clock_pkg::bcd_digit_t min1,
    output clock_pkg::bcd_digit_t hr0,
    output clock_pkg::bcd_digit_t hr1,
    output logic                  hour_carry
);

    localparam clock_pkg::bcd_digit_t HR1_LAST  = 4'(clock_pkg::HOUR_LAST / 10);
    localparam clock_pkg::bcd_digit_t HR0_LAST  = 4'(clock_pkg::HOUR_LAST % 10);
    localparam clock_pkg::bcd_digit_t HR1_FIRST = 4'(clock_pkg::HOUR_FIRST / 10);
    localparam clock_pkg::bcd_digit_t HR0_FIRST = 4'(clock_pkg::HOUR_FIRST % 10);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            min0       <= 4'(clock_pkg::RESET_MINUTES % 10);
            min1       <= 4'(clock_pkg::RESET_MINUTES / 10);
            hr0        <= 4'(clock_pkg::RESET_HOURS % 10);
            hr1        <= 4'(clock_pkg::RESET_HOURS / 10);
            hour_carry <= 1'b0;
        end else begin
            hour_carry <= 1'b0;

            if (advance_min) begin
                if (min0 == clock_pkg::MINUTE_UNITS_MAX) begin
                    min0 <= 4'd0;
                    if (min1 == clock_pkg::MINUTE_TENS_MAX) begin
                        min1       <= 4'd0;
                        hour_carry <= 1'b1; // 59 -> 00
                    end else begin
                        min1 <= min1 + 4'd1;
                    end
                end else begin
                    min0 <= min0 + 4'd1;
                end
            end

            if (advance_hr) begin
                if (hr1 == HR1_LAST && hr0 == HR0_LAST) begin
                    hr1 <= HR1_FIRST; // 12 -> 1
                    hr0 <= HR0_FIRST;
                end else if (hr0 == 4'd9) begin
                    hr1 <= hr1 + 4'd1;
                    hr0 <= 4'd0;
                end else begin
                    hr0 <= hr0 + 4'd1;
                end
            end
        end
    end

endmodule

// File: source/display_scanner.sv
`timescale 1ns/1ps

module display_scanner #(
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic                   clk_100mhz,
    input  logic                   rst,
    input  clock_pkg::bcd_digit_t  min0,
    input  clock_pkg::bcd_digit_t  min1,
    input  clock_pkg::bcd_digit_t  hr0,
    input  clock_pkg::bcd_digit_t  hr1,
    output display_pkg::segments_t min0_out,
    output display_pkg::segments_t min1_out,
    output display_pkg::segments_t hr0_out,
    output display_pkg::segments_t hr1_out
);

    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);
    localparam int SEL_W  = $clog2(display_pkg::DIGIT_COUNT);

    // scan order, units of minutes first
    localparam logic [SEL_W-1:0] SEL_MIN0 = SEL_W'(0);
    localparam logic [SEL_W-1:0] SEL_MIN1 = SEL_W'(1);
    localparam logic [SEL_W-1:0] SEL_HR0  = SEL_W'(2);
    localparam logic [SEL_W-1:0] SEL_HR1  = SEL_W'(3);

    logic [SCAN_W-1:0]      scan_cnt;
    logic [SEL_W-1:0]       digit_sel;
    clock_pkg::bcd_digit_t  sel_digit;
    display_pkg::segments_t sel_segments;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            scan_cnt  <= '0;
            digit_sel <= SEL_MIN0;
        end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            if (digit_sel == SEL_W'(display_pkg::DIGIT_COUNT - 1))
                digit_sel <= SEL_MIN0;
            else
                digit_sel <= digit_sel + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // one shared encoder for all four digits
    always_comb begin
        case (digit_sel)
            SEL_MIN0: sel_digit = min0;
            SEL_MIN1: sel_digit = min1;
            SEL_HR0:  sel_digit = hr0;
            default:  sel_digit = hr1;
        endcase
        if (digit_sel == SEL_HR1 && hr1 == 4'd0)
            sel_segments = display_pkg::SEG_BLANK; // no leading zero on hours
        else
            sel_segments = display_pkg::encode_digit(sel_digit);
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            min0_out <= display_pkg::SEG_BLANK;
            min1_out <= display_pkg::SEG_BLANK;
            hr0_out  <= display_pkg::SEG_BLANK;
            hr1_out  <= display_pkg::SEG_BLANK;
        end else begin
            case (digit_sel)
                SEL_MIN0: min0_out <= sel_segments;
                SEL_MIN1: min1_out <= sel_segments;
                SEL_HR0:  hr0_out  <= sel_segments;
                default:  hr1_out  <= sel_segments;
            endcase
        end
    end

endmodule

// File: source/clock_top.sv
`timescale 1ns/1ps

module clock_top #(
    parameter int CYCLES_PER_SECOND = 100_000_000,
    parameter int DEBOUNCE_CYCLES   = 1_000_000,
    parameter int SCAN_CYCLES       = 100_000
) (
    input  logic                   clk_100mhz,
    input  logic                   rst,
    input  logic                   btn_min,   // right button
    input  logic                   btn_hr,    // left button
    output logic                   blink,     // seconds LED
    output display_pkg::segments_t min0_out,
    output display_pkg::segments_t min1_out,
    output display_pkg::segments_t hr0_out,
    output display_pkg::segments_t hr1_out
);

    logic                  second_tick;
    logic                  blink_raw;
    logic                  btn_min_press;
    logic                  btn_hr_press;
    logic                  advance_min;
    logic                  advance_hr;
    logic                  hour_carry;
    clock_pkg::bcd_digit_t min0;
    clock_pkg::bcd_digit_t min1;
    clock_pkg::bcd_digit_t hr0;
    clock_pkg::bcd_digit_t hr1;

    tick_divider #(
        .CYCLES_PER_SECOND(CYCLES_PER_SECOND)
    ) i_tick_divider (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .second_tick(second_tick),
        .blink      (blink_raw)
    );

    button_debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_debounce_min (
        .clk_100mhz(clk_100mhz),
        .rst       (rst),
        .btn       (btn_min),
        .press     (btn_min_press)
    );

    button_debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_debounce_hr (
        .clk_100mhz(clk_100mhz),
        .rst       (rst),
        .btn       (btn_hr),
        .press     (btn_hr_press)
    );

    clock_control i_clock_control (
        .clk_100mhz   (clk_100mhz),
        .rst          (rst),
        .second_tick  (second_tick),
        .blink        (blink_raw),
        .btn_min_press(btn_min_press),
        .btn_hr_press (btn_hr_press),
        .hour_carry   (hour_carry),
        .advance_min  (advance_min),
        .advance_hr   (advance_hr),
        .blink_out    (blink)
    );

    time_counter i_time_counter (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .advance_min(advance_min),
        .advance_hr (advance_hr),
        .min0       (min0),
        .min1       (min1),
        .hr0        (hr0),
        .hr1        (hr1),
        .hour_carry (hour_carry)
    );

    display_scanner #(
        .SCAN_CYCLES(SCAN_CYCLES)
    ) i_display_scanner (
        .clk_100mhz(clk_100mhz),
        .rst       (rst),
        .min0      (min0),
        .min1      (min1),
        .hr0       (hr0),
        .hr1       (hr1),
        .min0_out  (min0_out),
        .min1_out  (min1_out),
        .hr0_out   (hr0_out),
        .hr1_out   (hr1_out)
    );

endmodule

// File: bench/clock_props.sv
`timescale 1ns/1ps

module clock_props (
    input logic clk_100mhz,
    input logic rst,
    input logic advance_min,
    input logic advance_hr,
    input logic hour_carry
);

    int fail_count = 0;

    // time counter takes one advance per cycle
    assert property (@(posedge clk_100mhz) disable iff (rst) !(advance_min && advance_hr))
        else begin
            $error("advance_min and advance_hr high together");
            fail_count++;
        end

    // two coinciding minute requests give two back-to-back strobes, never three
    assert property (@(posedge clk_100mhz) disable iff (rst)
        advance_min && $past(advance_min) |-> !$past(advance_min, 2))
        else begin
            $error("advance_min held longer than its requests");
            fail_count++;
        end

    assert property (@(posedge clk_100mhz) disable iff (rst)
        advance_hr && $past(advance_hr) |-> !$past(advance_hr, 2))
        else begin
            $error("advance_hr held longer than its requests");
            fail_count++;
        end

    assert property (@(posedge clk_100mhz) disable iff (rst)
        $past(hour_carry, 2) && !$past(advance_hr) |-> advance_hr)
        else begin
            $error("hour_carry not followed by advance_hr within two cycles");
            fail_count++;
        end

    assert property (@(posedge clk_100mhz)
        $past(rst) |-> !advance_min && !advance_hr && !hour_carry)
        else begin
            $error("strobe high during or just after reset");
            fail_count++;
        end

endmodule

bind clock_control clock_props i_clock_props (
    .clk_100mhz (clk_100mhz),
    .rst        (rst),
    .advance_min(advance_min),
    .advance_hr (advance_hr),
    .hour_carry (hour_carry)
);

// File: bench/clock_tb.sv
`timescale 1ns/1ps

module clock_tb;

    localparam int CPS           = 64;
    localparam int DEBOUNCE      = 4;
    localparam int SCAN          = 2;
    localparam int SCAN_TIMEOUT  = display_pkg::DIGIT_COUNT * SCAN + 2;
    localparam int PRESS_TIMEOUT = (DEBOUNCE + 3) + 4 + SCAN_TIMEOUT; // debounce, control, carry, scan
    localparam int HOLD          = DEBOUNCE + 4;
    localparam int PRESS_SETUP   = CPS - (DEBOUNCE + 2); // btn edge to press strobe here
    localparam int MINUTE_LAST   = int'(clock_pkg::MINUTE_TENS_MAX) * 10
                                   + int'(clock_pkg::MINUTE_UNITS_MAX);

    logic                   clk_100mhz;
    logic                   rst;
    logic                   btn_min;
    logic                   btn_hr;
    logic                   blink;
    logic                   blink_last;
    display_pkg::segments_t min0_out;
    display_pkg::segments_t min1_out;
    display_pkg::segments_t hr0_out;
    display_pkg::segments_t hr1_out;

    int hours;
    int minutes;
    int toggles;
    int test_errors;
    int tests_ok;
    int tests_bad;
    int len;
    int seed = 32'hcfbb_5733;

    initial begin
        clk_100mhz = 1'b0;
        forever #10 clk_100mhz = ~clk_100mhz;
    end

    clock_top #(
        .CYCLES_PER_SECOND(CPS),
        .DEBOUNCE_CYCLES  (DEBOUNCE),
        .SCAN_CYCLES      (SCAN)
    ) i_clock_top (
        .clk_100mhz(clk_100mhz),
        .rst       (rst),
        .btn_min   (btn_min),
        .btn_hr    (btn_hr),
        .blink     (blink),
        .min0_out  (min0_out),
        .min1_out  (min1_out),
        .hr0_out   (hr0_out),
        .hr1_out   (hr1_out)
    );

    function automatic display_pkg::segments_t digit_seg(input int value);
        return display_pkg::encode_digit(4'(value));
    endfunction

    // no leading zero on the hours
    function automatic display_pkg::segments_t hr1_seg(input int h);
        return (h / 10 == 0) ? display_pkg::SEG_BLANK : digit_seg(h / 10);
    endfunction

    function automatic void step_hour();
        hours = (hours == clock_pkg::HOUR_LAST) ? clock_pkg::HOUR_FIRST : hours + 1;
    endfunction

    function automatic void step_minute();
        minutes = minutes + 1;
        if (minutes > MINUTE_LAST) begin
            minutes = 0;
            step_hour(); // carry into hours
        end
    endfunction

    function automatic logic displayed_ok();
        return min0_out === digit_seg(minutes % 10) && min1_out === digit_seg(minutes / 10)
            && hr0_out === digit_seg(hours % 10) && hr1_out === hr1_seg(hours);
    endfunction

    task automatic report_seg(input string name, input logic [6:0] exp, input logic [6:0] got);
        if (exp !== got)
            $display("** Error: %s expected 0x%02h got 0x%02h", name, exp, got);
    endtask

    task automatic apply_reset();
        @(posedge clk_100mhz);
        rst <= 1'b1;
        repeat (4) @(posedge clk_100mhz);
        rst <= 1'b0;
        hours   = clock_pkg::RESET_HOURS;
        minutes = clock_pkg::RESET_MINUTES;
    endtask

    task automatic hold_button(input logic is_hour, input int cycles);
        @(posedge clk_100mhz);
        if (is_hour) btn_hr <= 1'b1;
        else btn_min <= 1'b1;
        repeat (cycles) @(posedge clk_100mhz);
        btn_hr  <= 1'b0;
        btn_min <= 1'b0;
        repeat (HOLD) @(posedge clk_100mhz); // let the release settle
    endtask

    // both buttons in the same cycle
    task automatic hold_both(input int cycles);
        @(posedge clk_100mhz);
        btn_min <= 1'b1;
        btn_hr  <= 1'b1;
        repeat (cycles) @(posedge clk_100mhz);
        btn_hr  <= 1'b0;
        btn_min <= 1'b0;
        repeat (HOLD) @(posedge clk_100mhz);
    endtask

    // samples on the falling edge, counts blink changes on the way
    task automatic wait_tick();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_100mhz);
            waited++;
            if (blink !== blink_last) toggles++;
            blink_last = blink;
        end while (!i_clock_top.second_tick && waited <= CPS);
        assert (i_clock_top.second_tick) else begin
            $display("second tick did not come within %0d cycles", CPS + 1);
            test_errors++;
        end
    endtask

    task automatic check_display(input int timeout);
        int waited;
        waited = 0;
        @(negedge clk_100mhz);
        while (!displayed_ok() && waited < timeout) begin
            @(negedge clk_100mhz);
            waited++;
        end
        assert (displayed_ok()) else begin
            report_seg("min0_out", digit_seg(minutes % 10), min0_out);
            report_seg("min1_out", digit_seg(minutes / 10), min1_out);
            report_seg("hr0_out", digit_seg(hours % 10), hr0_out);
            report_seg("hr1_out", hr1_seg(hours), hr1_out);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        rst         = 1'b1;
        btn_min     = 1'b0;
        btn_hr      = 1'b0;
        blink_last  = 1'b0;
        toggles     = 0;
        test_errors = 0;
        tests_ok    = 0;
        tests_bad   = 0;

        apply_reset();
        check_display(SCAN_TIMEOUT);
        assert (blink == 1'b0) else begin
            $display("** Error: blink expected 0x0 got 0x%0h", blink);
            test_errors++;
        end
        end_test("reset shows 12:00");

        apply_reset();
        wait_tick();
        toggles    = 0;
        blink_last = blink;
        repeat (clock_pkg::SECONDS_MAX) wait_tick();
        assert (toggles == 2 * clock_pkg::SECONDS_MAX) else begin
            $display("** Error: blink toggles expected 0x%0h got 0x%0h",
                     2 * clock_pkg::SECONDS_MAX, toggles);
            test_errors++;
        end
        step_minute();
        check_display(SCAN_TIMEOUT + 3);
        end_test("sixty seconds give 12:01");

        apply_reset();
        for (int i = 0; i <= MINUTE_LAST; i++) begin
            hold_button(1'b0, HOLD);
            step_minute();
            check_display(PRESS_TIMEOUT);
        end
        end_test("minute presses wrap to 1:00");

        apply_reset();
        for (int i = 0; i < clock_pkg::HOUR_LAST; i++) begin
            hold_button(1'b1, HOLD);
            step_hour();
            check_display(PRESS_TIMEOUT);
        end
        end_test("hour presses step 1 to 12");

        apply_reset();
        for (int i = 0; i < MINUTE_LAST; i++) begin
            hold_button(1'b0, HOLD);
            step_minute();
        end
        check_display(PRESS_TIMEOUT);
        hold_both(HOLD); // waiting hour press then the carry, back to back
        step_minute();
        step_hour();
        check_display(PRESS_TIMEOUT);
        end_test("both buttons at 12:59 give 2:00");

        apply_reset();
        repeat (clock_pkg::SECONDS_MAX) wait_tick();
        repeat (PRESS_SETUP - 1) @(posedge clk_100mhz); // press lands on the 60th tick
        hold_button(1'b0, HOLD);
        step_minute();
        step_minute();
        check_display(PRESS_TIMEOUT);
        end_test("press on rollover counts twice");

        apply_reset();
        for (int g = 0; g < 8; g++) begin
            len = 1 + ($unsigned($random(seed)) % 3);
            hold_button(g % 2 == 1, len);
        end
        repeat (PRESS_TIMEOUT) @(posedge clk_100mhz);
        check_display(0);
        end_test("short glitches are ignored");

        $display("tests ok: %0d, tests failed: %0d, assertion failures: %0d", tests_ok,
                 tests_bad, i_clock_top.i_clock_control.i_clock_props.fail_count);
        if (tests_bad == 0 && i_clock_top.i_clock_control.i_clock_props.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/clock_pkg.sv
source/display_pkg.sv
source/tick_divider.sv
source/button_debouncer.sv
source/clock_control.sv
source/time_counter.sv
source/display_scanner.sv
source/clock_top.sv
bench/clock_props.sv
bench/clock_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the clock testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module clock_tb -f project.f -o clock_sim \
    && ./obj_dir/clock_sim | tee /dev/stderr | grep "^Test passed$" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
